// File: uart_echo_pkg.sv
// uart echo shared definitions
// byte width and the state encodings of receiver, queue and transmitter
`default_nettype none

package uart_echo_pkg;

  // 8N1 frame, fixed
  localparam int unsigned data_bits = 8;

  typedef enum logic [1:0] {
    rx_st_idle,
    rx_st_start,
    rx_st_data,
    rx_st_stop
  } rx_state_e;

  typedef enum logic [2:0] {
    tx_st_idle,
    tx_st_start_bit,
    tx_st_data_bits,
    tx_st_stop_bit,
    tx_st_wait_go_low
  } tx_state_e;

  typedef enum logic [1:0] {
    q_st_idle,
    q_st_sending,
    q_st_ack
  } queue_state_e;

endpackage

`default_nettype wire

// File: uart_rx.sv
// uart receiver, 8N1
// oversamples rx at the system clock and samples each bit at mid-bit
// emits a one-cycle byte strobe, or a framing-error pulse on a low stop bit
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int unsigned clock_frequency_hz = 50_000_000,
  parameter int unsigned baud_rate = 115_200
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 rx,
  output logic [uart_echo_pkg::data_bits-1:0] rx_data,
  output logic                                rx_valid,
  output logic                                frame_error
);

  import uart_echo_pkg::*;

  localparam int unsigned bit_time = clock_frequency_hz / baud_rate;
  localparam int unsigned half_bit = bit_time / 2;
  localparam int unsigned cnt_w = (bit_time < 2) ? 1 : $clog2(bit_time);

  rx_state_e state;

  logic rx_meta;
  logic rx_sync;

  logic [cnt_w-1:0] bit_time_cnt;
  logic [$clog2(data_bits)-1:0] bit_cnt;
  logic [data_bits-1:0] shift_reg;

  // two-flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // bits arrive lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == rx_st_data && bit_time_cnt == 0) begin
      shift_reg <= {rx_sync, shift_reg[data_bits-1:1]};
    end
  end

  assign rx_data = shift_reg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= rx_st_idle;
      bit_time_cnt <= '0;
      bit_cnt      <= '0;
      rx_valid     <= 1'b0;
      frame_error  <= 1'b0;
    end else begin
      rx_valid    <= 1'b0;
      frame_error <= 1'b0;
      unique case (state)
        rx_st_idle: begin
          // first low sample counts as one tick of the half bit
          if (!rx_sync) begin
            bit_time_cnt <= cnt_w'(half_bit - 1);
            state        <= rx_st_start;
          end
        end
        rx_st_start: begin
          bit_time_cnt <= bit_time_cnt - 1'b1;
          if (bit_time_cnt == 0) begin
            if (!rx_sync) begin
              bit_time_cnt <= cnt_w'(bit_time - 1);
              bit_cnt      <= '0;
              state        <= rx_st_data;
            end else begin
              // glitch, not a real start bit
              state <= rx_st_idle;
            end
          end
        end
        rx_st_data: begin
          bit_time_cnt <= bit_time_cnt - 1'b1;
          if (bit_time_cnt == 0) begin
            bit_time_cnt <= cnt_w'(bit_time - 1);
            bit_cnt      <= bit_cnt + 1'b1;
            if (bit_cnt == data_bits - 1) begin
              state <= rx_st_stop;
            end
          end
        end
        rx_st_stop: begin
          bit_time_cnt <= bit_time_cnt - 1'b1;
          if (bit_time_cnt == 0) begin
            // mid stop bit, hand the byte over or flag it
            if (rx_sync) begin
              rx_valid <= 1'b1;
            end else begin
              frame_error <= 1'b1;
            end
            state <= rx_st_idle;
          end
        end
        default: begin
          state <= rx_st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: echo_queue.sv
// echo byte queue
// circular FIFO between receiver and transmitter with sticky overrun,
// plus the go/bsy sequencer that hands bytes to the transmitter in order
`timescale 1ns/1ps
`default_nettype none

module echo_queue #(
  parameter int unsigned queue_depth = 4
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire  [uart_echo_pkg::data_bits-1:0] rx_data,
  input  wire                                 rx_valid,
  input  wire                                 tx_pause,
  input  wire                                 bsy,
  output logic [uart_echo_pkg::data_bits-1:0] tx_data,
  output logic                                go,
  output logic                                overrun
);

  import uart_echo_pkg::*;

  localparam int unsigned ptr_w = $clog2(queue_depth);

  queue_state_e state;

  logic [data_bits-1:0] mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0] count;

  logic full;
  logic empty;
  logic push;
  logic pop;
  logic has_data;

  assign full  = (count == (ptr_w + 1)'(queue_depth));
  assign empty = (count == '0);
  assign push  = rx_valid && !full;
  // acknowledge: transmitter dropped bsy while go is still up
  assign pop   = (state == q_st_ack) && !bsy;

  // a byte being written this cycle is readable when go rises
  assign has_data = !empty || rx_valid;

  // head entry, held while go is high since a full queue blocks writes
  assign tx_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rx_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // sticky until reset
      if (rx_valid && full) begin
        overrun <= 1'b1;
      end
    end
  end

  // go/bsy sequencer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= q_st_idle;
      go    <= 1'b0;
    end else begin
      unique case (state)
        q_st_idle: begin
          if (has_data && !tx_pause) begin
            go    <= 1'b1;
            state <= q_st_sending;
          end
        end
        q_st_sending: begin
          if (bsy) begin
            state <= q_st_ack;
          end
        end
        q_st_ack: begin
          if (!bsy) begin
            go    <= 1'b0;
            state <= q_st_idle;
          end
        end
        default: begin
          go    <= 1'b0;
          state <= q_st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
// uart transmitter, 8N1
// sends tx_data when go is raised, holds bsy while the frame is on the line,
// then waits for go to drop before accepting the next byte
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int unsigned clock_frequency_hz = 50_000_000,
  parameter int unsigned baud_rate = 115_200
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire [uart_echo_pkg::data_bits-1:0] tx_data,
  input  wire                                go,
  output logic                               tx,
  output logic                               bsy
);

  import uart_echo_pkg::*;

  localparam int unsigned bit_time = clock_frequency_hz / baud_rate;
  localparam int unsigned cnt_w = (bit_time < 2) ? 1 : $clog2(bit_time);

  tx_state_e state;

  logic [$clog2(data_bits)-1:0] bit_count;
  logic [cnt_w-1:0] bit_time_cnt;

  // line level and busy straight from the state
  always_comb begin
    unique case (state)
      tx_st_idle: begin
        tx  = 1'b1;
        bsy = go;
      end
      tx_st_start_bit: begin
        tx  = 1'b0;
        bsy = 1'b1;
      end
      tx_st_data_bits: begin
        tx  = tx_data[bit_count];
        bsy = 1'b1;
      end
      tx_st_stop_bit: begin
        tx  = 1'b1;
        bsy = 1'b1;
      end
      tx_st_wait_go_low: begin
        tx  = 1'b1;
        bsy = 1'b0;
      end
      default: begin
        tx  = 1'b1;
        bsy = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= tx_st_idle;
      bit_count    <= '0;
      bit_time_cnt <= '0;
    end else begin
      unique case (state)
        tx_st_idle: begin
          // count reloads one short, the zero count is a tick too
          if (go) begin
            bit_time_cnt <= cnt_w'(bit_time - 1);
            state        <= tx_st_start_bit;
          end
        end
        tx_st_start_bit: begin
          bit_time_cnt <= bit_time_cnt - 1'b1;
          if (bit_time_cnt == 0) begin
            bit_time_cnt <= cnt_w'(bit_time - 1);
            bit_count    <= '0;
            state        <= tx_st_data_bits;
          end
        end
        tx_st_data_bits: begin
          bit_time_cnt <= bit_time_cnt - 1'b1;
          if (bit_time_cnt == 0) begin
            bit_time_cnt <= cnt_w'(bit_time - 1);
            bit_count    <= bit_count + 1'b1;
            if (bit_count == data_bits - 1) begin
              bit_count <= '0;
              state     <= tx_st_stop_bit;
            end
          end
        end
        tx_st_stop_bit: begin
          bit_time_cnt <= bit_time_cnt - 1'b1;
          if (bit_time_cnt == 0) begin
            state <= tx_st_wait_go_low;
          end
        end
        tx_st_wait_go_low: begin
          // sender acknowledges by dropping go
          if (!go) begin
            state <= tx_st_idle;
          end
        end
        default: begin
          state <= tx_st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: uart_echo_top.sv
// uart echo channel
// receiver feeds a byte queue, the queue feeds the transmitter,
// so every good byte on rx comes back on tx in arrival order
`timescale 1ns/1ps
`default_nettype none

module uart_echo_top #(
  parameter int unsigned clock_frequency_hz = 50_000_000,
  parameter int unsigned baud_rate = 115_200,
  parameter int unsigned queue_depth = 4
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  rx,
  input  wire  tx_pause,
  output logic tx,
  output logic overrun,
  output logic frame_error
);

  import uart_echo_pkg::*;

  logic [data_bits-1:0] rx_data;
  logic rx_valid;
  logic [data_bits-1:0] tx_data;
  logic go;
  logic bsy;

  uart_rx #(
    .clock_frequency_hz(clock_frequency_hz),
    .baud_rate(baud_rate)
  ) uart_rx_i (
    .clk(clk),
    .rst_n(rst_n),
    .rx(rx),
    .rx_data(rx_data),
    .rx_valid(rx_valid),
    .frame_error(frame_error)
  );

  echo_queue #(
    .queue_depth(queue_depth)
  ) echo_queue_i (
    .clk(clk),
    .rst_n(rst_n),
    .rx_data(rx_data),
    .rx_valid(rx_valid),
    .tx_pause(tx_pause),
    .bsy(bsy),
    .tx_data(tx_data),
    .go(go),
    .overrun(overrun)
  );

  uart_tx #(
    .clock_frequency_hz(clock_frequency_hz),
    .baud_rate(baud_rate)
  ) uart_tx_i (
    .clk(clk),
    .rst_n(rst_n),
    .tx_data(tx_data),
    .go(go),
    .tx(tx),
    .bsy(bsy)
  );

endmodule

`default_nettype wire

// File: tb_uart_echo.sv
// testbench for the uart echo channel
// drives 8N1 frames into rx, decodes tx at mid-bit and compares with a byte model
`timescale 1ns/1ps
`default_nettype none

module tb_uart_echo;

  localparam int unsigned clock_frequency_hz = 10_000_000;
  localparam int unsigned baud_rate = 1_000_000;
  localparam int unsigned queue_depth = 4;
  localparam int bit_clks = clock_frequency_hz / baud_rate;
  localparam int bit_ns = 100 * bit_clks;
  localparam int n_single = 8;
  localparam int n_burst = 20;
  localparam int n_mixed = 12;
  localparam int n_paused = queue_depth + 3;
  localparam int total_frames = n_single + n_burst + n_mixed + n_paused;
  // two 12-bit-time slots per frame plus room for idle checks and drains
  localparam int watchdog_ns = total_frames * 12 * bit_ns * 2 + 600 * bit_ns;

  logic clk;
  logic rst_n;
  logic rx;
  logic tx_pause;
  wire  tx;
  wire  overrun;
  wire  frame_error;

  // expected bytes, decoded bytes and the model's side state
  logic [7:0] expected[$];
  logic [7:0] received[$];
  int fe_expected = 0;
  int fe_seen = 0;
  int fe_base = 0;
  bit paused = 1'b0;
  int paused_kept = 0;
  bit overrun_expected = 1'b0;

  int errors = 0;
  int stop_errors = 0;
  int errors_at_start = 0;
  int tests_run = 0;
  int tests_passed = 0;
  int exp_base = 0;
  int rcv_base = 0;

  logic [7:0] mon_byte;
  logic mon_stop;

  uart_echo_top #(
    .clock_frequency_hz(clock_frequency_hz),
    .baud_rate(baud_rate),
    .queue_depth(queue_depth)
  ) uart_echo_top_i (
    .clk(clk),
    .rst_n(rst_n),
    .rx(rx),
    .tx_pause(tx_pause),
    .tx(tx),
    .overrun(overrun),
    .frame_error(frame_error)
  );

  always #50 clk = ~clk;

  always @(negedge clk) begin
    if (rst_n && frame_error) begin
      fe_seen++;
    end
  end

  // serial monitor finds the start edge and samples each bit in the middle
  initial begin
    wait (rst_n === 1'b1);
    forever begin
      @(negedge tx);
      repeat (bit_clks / 2) @(negedge clk);
      for (int k = 0; k < 8; k++) begin
        repeat (bit_clks) @(negedge clk);
        mon_byte[k] = tx;
      end
      repeat (bit_clks) @(negedge clk);
      mon_stop = tx;
      if (mon_stop !== 1'b1) begin
        $display("CHECK FAILED tx stop bit: got 0x%0h expected 0x1", mon_stop);
        stop_errors++;
      end
      received.push_back(mon_byte);
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired: the run did not end within %0d ns", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  // starts and ends on a falling clock edge
  task automatic send_frame(input logic [7:0] data, input bit bad_stop);
    rx = 1'b0;
    repeat (bit_clks) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = data[i];
      repeat (bit_clks) @(negedge clk);
    end
    rx = bad_stop ? 1'b0 : 1'b1;
    repeat (bit_clks) @(negedge clk);
    rx = 1'b1;
    // receiver needs idle line after a low stop bit to drop the false start
    if (bad_stop) begin
      repeat (2 * bit_clks) @(negedge clk);
    end
  endtask

  task automatic model_frame(input logic [7:0] data, input bit bad_stop);
    if (bad_stop) begin
      fe_expected++;
    end else if (paused && paused_kept >= queue_depth) begin
      overrun_expected = 1'b1;
    end else begin
      expected.push_back(data);
      if (paused) begin
        paused_kept++;
      end
    end
  endtask

  task automatic wait_for_echoes(input int quiet_bits);
    int target;
    int waited;
    target = rcv_base + expected.size() - exp_base;
    waited = 0;
    while (received.size() < target && waited < (queue_depth + 2) * 12 * bit_clks) begin
      @(negedge clk);
      waited++;
    end
    if (received.size() < target) begin
      $display("timed out waiting for echoes, %0d of %0d bytes came back",
               received.size() - rcv_base, target - rcv_base);
      errors++;
    end
    repeat (quiet_bits * bit_clks) @(negedge clk);
  endtask

  task automatic compare_echoes();
    int n_exp;
    int n_rcv;
    n_exp = expected.size() - exp_base;
    n_rcv = received.size() - rcv_base;
    if (n_rcv != n_exp) begin
      $display("CHECK FAILED echo count: got 0x%0h expected 0x%0h", n_rcv, n_exp);
      errors++;
    end
    for (int i = 0; i < n_exp && i < n_rcv; i++) begin
      if (received[rcv_base + i] !== expected[exp_base + i]) begin
        $display("CHECK FAILED tx byte %0d: got 0x%02h expected 0x%02h",
                 i, received[rcv_base + i], expected[exp_base + i]);
        errors++;
      end
    end
    if (fe_seen - fe_base != fe_expected) begin
      $display("CHECK FAILED frame_error pulses: got 0x%0h expected 0x%0h",
               fe_seen - fe_base, fe_expected);
      errors++;
    end
  endtask

  task automatic start_test();
    errors_at_start = errors + stop_errors;
    exp_base = expected.size();
    rcv_base = received.size();
    fe_base = fe_seen;
    fe_expected = 0;
  endtask

  task automatic finish_test(input string name);
    int delta;
    delta = errors + stop_errors - errors_at_start;
    tests_run++;
    if (delta == 0) begin
      tests_passed++;
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, delta);
    end
  endtask

  initial begin
    logic [7:0] data;
    bit bad;
    void'($urandom(77531));
    clk = 1'b0;
    rx = 1'b1;
    tx_pause = 1'b0;
    apply_reset();

    // idle outputs after reset
    start_test();
    for (int c = 0; c < 20 * bit_clks; c++) begin
      @(negedge clk);
      if (tx !== 1'b1 || overrun !== 1'b0 || frame_error !== 1'b0) begin
        $write("CHECK FAILED idle outputs: got tx=0x%0h overrun=0x%0h frame_error=0x%0h",
               tx, overrun, frame_error);
        $display(" expected tx=0x1 overrun=0x0 frame_error=0x0");
        errors++;
        break;
      end
    end
    finish_test("reset state");

    start_test();
    for (int i = 0; i < n_single; i++) begin
      data = 8'($urandom);
      send_frame(data, 1'b0);
      model_frame(data, 1'b0);
      wait_for_echoes(0);
    end
    wait_for_echoes(15);
    compare_echoes();
    finish_test("single echo");

    start_test();
    for (int i = 0; i < n_burst; i++) begin
      data = 8'($urandom);
      send_frame(data, 1'b0);
      model_frame(data, 1'b0);
    end
    wait_for_echoes(15);
    compare_echoes();
    if (overrun !== overrun_expected) begin
      $display("CHECK FAILED overrun: got 0x%0h expected 0x%0h", overrun, overrun_expected);
      errors++;
    end
    finish_test("burst");

    start_test();
    for (int i = 0; i < n_mixed; i++) begin
      data = 8'($urandom);
      bad = (i % 4 == 1) || (($urandom % 5) == 0);
      send_frame(data, bad);
      model_frame(data, bad);
    end
    wait_for_echoes(15);
    compare_echoes();
    finish_test("framing error");

    // queue fills while paused and the extra bytes are lost
    start_test();
    tx_pause = 1'b1;
    paused = 1'b1;
    paused_kept = 0;
    for (int i = 0; i < n_paused; i++) begin
      data = 8'($urandom);
      send_frame(data, 1'b0);
      model_frame(data, 1'b0);
    end
    repeat (5 * bit_clks) @(negedge clk);
    if (received.size() != rcv_base) begin
      $display("CHECK FAILED tx frames while paused: got 0x%0h expected 0x0",
               received.size() - rcv_base);
      errors++;
    end
    if (overrun !== overrun_expected) begin
      $display("CHECK FAILED overrun: got 0x%0h expected 0x%0h", overrun, overrun_expected);
      errors++;
    end
    tx_pause = 1'b0;
    paused = 1'b0;
    wait_for_echoes(15);
    compare_echoes();
    if (overrun !== overrun_expected) begin
      $display("CHECK FAILED overrun: got 0x%0h expected 0x%0h", overrun, overrun_expected);
      errors++;
    end
    apply_reset();
    overrun_expected = 1'b0;
    @(negedge clk);
    if (overrun !== overrun_expected || tx !== 1'b1) begin
      $display("CHECK FAILED after reset: got overrun=0x%0h tx=0x%0h expected 0x0 and 0x1",
               overrun, tx);
      errors++;
    end
    finish_test("pause and overrun");

    $display("%0d tests run, %0d passed, %0d errors",
             tests_run, tests_passed, errors + stop_errors);
    if (errors + stop_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_echo.f
uart_echo_pkg.sv
uart_rx.sv
echo_queue.sv
uart_tx.sv
uart_echo_top.sv
tb_uart_echo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the uart echo testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_uart_echo
build_dir=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing -j 0 --top-module "$top" --Mdir "$build_dir" -f uart_echo.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$("./$build_dir/V$top")
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
